/* source/apb_timer_settings.svh */
`ifndef APB_TIMER_SETTINGS_SVH
`define APB_TIMER_SETTINGS_SVH

// APB and native bus widths
`define APB_TIMER_ADDR_W 12
`define APB_TIMER_DATA_W 32

// Register byte offsets
`define TIMER_CTRL_OFS   12'h000
`define TIMER_LOAD_OFS   12'h004
`define TIMER_COUNT_OFS  12'h008
`define TIMER_STATUS_OFS 12'h00C

// Cycles from native request to ack, at least 1
`define TIMER_ACK_DELAY 2

`endif

/* source/apb_timer_pkg.sv */
package apb_timer_pkg;

    // Bridge FSM
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_complete
    } bridge_state_e;

    // Native access direction
    typedef enum logic {
        op_read,
        op_write
    } access_op_e;

    // Reload behaviour at expiry
    typedef enum logic {
        mode_oneshot,
        mode_periodic
    } timer_mode_e;

endpackage

/* source/apb_timer_ifs.sv */
`include "apb_timer_settings.svh"

// Native register request, one outstanding at a time
interface reg_req_if;
    import apb_timer_pkg::*;

    logic                           req;
    access_op_e                     op;
    logic [`APB_TIMER_ADDR_W-1:0]   addr;
    logic [`APB_TIMER_DATA_W-1:0]   wdata;
    logic                           ack;
    logic [`APB_TIMER_DATA_W-1:0]   rdata;

    modport master (
        output req,
        output op,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport slave (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );
endinterface

// Register bank to counter
interface timer_ctl_if;
    import apb_timer_pkg::*;

    logic                           start;
    logic                           stop;
    timer_mode_e                    mode;
    logic [`APB_TIMER_DATA_W-1:0]   load_value;
    logic [`APB_TIMER_DATA_W-1:0]   count;
    logic                           running;
    logic                           expired;

    modport regs (
        output start,
        output stop,
        output mode,
        output load_value,
        input  count,
        input  running,
        input  expired
    );

    modport core (
        input  start,
        input  stop,
        input  mode,
        input  load_value,
        output count,
        output running,
        output expired
    );
endinterface

/* source/apb_bridge.sv */
`include "apb_timer_settings.svh"

module apb_bridge (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`APB_TIMER_ADDR_W-1:0]    paddr,
    input  logic [`APB_TIMER_DATA_W-1:0]    pwdata,
    output logic [`APB_TIMER_DATA_W-1:0]    prdata,
    output logic                            pready,
    reg_req_if.master                       bus
);
    import apb_timer_pkg::*;

    bridge_state_e                  state;
    bridge_state_e                  next_state;
    logic                           setup;
    logic [`APB_TIMER_DATA_W-1:0]   rdata_q;

    // APB setup phase
    assign setup = psel && !penable;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (setup) begin
                    next_state = st_wait;
                end
            end
            st_wait: begin
                if (bus.ack) begin
                    next_state = st_complete;
                end
            end
            st_complete: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Held until the completion cycle
    always_ff @(posedge clk) begin
        if (state == st_wait && bus.ack) begin
            rdata_q <= bus.rdata;
        end
    end

    // Request strobe on the setup cycle only
    assign bus.req   = (state == st_idle) && setup;
    assign bus.op    = pwrite ? op_write : op_read;
    assign bus.addr  = paddr;
    assign bus.wdata = pwdata;

    assign pready = (state == st_complete);
    assign prdata = (state == st_complete) ? rdata_q : '0;

endmodule

/* source/timer_regs.sv */
`include "apb_timer_settings.svh"

module timer_regs (
    input  logic        clk,
    input  logic        rst_n,
    reg_req_if.slave    bus,
    timer_ctl_if.regs   ctl,
    output logic        irq
);
    import apb_timer_pkg::*;

    localparam int DLY_W = $clog2(`TIMER_ACK_DELAY + 1);

    logic                           pend_q;
    logic [DLY_W-1:0]               dly_q;
    access_op_e                     op_q;
    logic [`APB_TIMER_ADDR_W-1:0]   addr_q;
    logic [`APB_TIMER_DATA_W-1:0]   wdata_q;

    timer_mode_e                    mode_q;
    logic                           irq_en_q;
    logic [`APB_TIMER_DATA_W-1:0]   load_q;
    logic                           status_q;

    logic                           wr_ack;
    logic                           ctrl_wr;
    logic                           load_wr;
    logic                           status_clr;

    // Pending request and ack delay
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            dly_q  <= '0;
        end else if (bus.req) begin
            pend_q <= 1'b1;
            dly_q  <= DLY_W'(`TIMER_ACK_DELAY - 1);
        end else if (bus.ack) begin
            pend_q <= 1'b0;
        end else if (pend_q) begin
            dly_q <= dly_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req) begin
            op_q    <= bus.op;
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end
    end

    assign bus.ack = pend_q && (dly_q == '0);

    assign wr_ack     = bus.ack && (op_q == op_write);
    assign ctrl_wr    = wr_ack && (addr_q == `TIMER_CTRL_OFS);
    assign load_wr    = wr_ack && (addr_q == `TIMER_LOAD_OFS);
    assign status_clr = wr_ack && (addr_q == `TIMER_STATUS_OFS) && wdata_q[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q   <= mode_oneshot;
            irq_en_q <= 1'b0;
            load_q   <= '0;
            status_q <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                mode_q   <= timer_mode_e'(wdata_q[1]);
                irq_en_q <= wdata_q[2];
            end
            if (load_wr) begin
                load_q <= wdata_q;
            end
            // Expiry wins over a simultaneous clear
            status_q <= ctl.expired || (status_q && !status_clr);
        end
    end

    // Read mux, sampled by the bridge at ack
    always_comb begin
        case (addr_q)
            `TIMER_CTRL_OFS: begin
                bus.rdata = {{(`APB_TIMER_DATA_W - 3){1'b0}},
                             irq_en_q, mode_q == mode_periodic, ctl.running};
            end
            `TIMER_LOAD_OFS: begin
                bus.rdata = load_q;
            end
            `TIMER_COUNT_OFS: begin
                bus.rdata = ctl.count;
            end
            `TIMER_STATUS_OFS: begin
                bus.rdata = {{(`APB_TIMER_DATA_W - 1){1'b0}}, status_q};
            end
            default: begin
                bus.rdata = '0;
            end
        endcase
    end

    assign ctl.start      = ctrl_wr && wdata_q[0];
    assign ctl.stop       = ctrl_wr && !wdata_q[0];
    assign ctl.mode       = mode_q;
    assign ctl.load_value = load_q;

    assign irq = status_q && irq_en_q;

endmodule

/* source/timer_core.sv */
`include "apb_timer_settings.svh"

module timer_core (
    input  logic        clk,
    input  logic        rst_n,
    timer_ctl_if.core   ctl
);
    import apb_timer_pkg::*;

    logic [`APB_TIMER_DATA_W-1:0]   count_q;
    logic                           running_q;
    logic                           at_zero;

    assign at_zero = (count_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q   <= '0;
            running_q <= 1'b0;
        end else if (ctl.start) begin
            // Restart also reloads a running timer
            count_q   <= ctl.load_value;
            running_q <= 1'b1;
        end else if (ctl.stop) begin
            running_q <= 1'b0;
        end else if (running_q) begin
            if (at_zero) begin
                if (ctl.mode == mode_periodic) begin
                    count_q <= ctl.load_value;
                end else begin
                    running_q <= 1'b0;
                end
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // One pulse per expiry, in the cycle count shows zero
    assign ctl.expired = running_q && at_zero;

    assign ctl.count   = count_q;
    assign ctl.running = running_q;

endmodule

/* source/apb_timer.sv */
`include "apb_timer_settings.svh"

module apb_timer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`APB_TIMER_ADDR_W-1:0]    paddr,
    input  logic [`APB_TIMER_DATA_W-1:0]    pwdata,
    output logic [`APB_TIMER_DATA_W-1:0]    prdata,
    output logic                            pready,
    output logic                            irq
);

    reg_req_if   req_bus ();
    timer_ctl_if ctl_bus ();

    apb_bridge u_bridge (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .bus     (req_bus.master)
    );

    timer_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (req_bus.slave),
        .ctl   (ctl_bus.regs),
        .irq   (irq)
    );

    timer_core u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .ctl   (ctl_bus.core)
    );

endmodule

/* dv/apb_timer_chk.sv */
`include "apb_timer_settings.svh"

module apb_timer_chk (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic req,
    input logic ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Native request is a strobe
    req_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        req |=> !req)
        else begin
            fail_count++;
            $error("native req held longer than one cycle");
        end

    // Fixed ack latency, no early or late ack
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> ##(`TIMER_ACK_DELAY) ack)
        else begin
            fail_count++;
            $error("native ack missing after req");
        end

    ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(req, `TIMER_ACK_DELAY))
        else begin
            fail_count++;
            $error("native ack without matching req");
        end

    pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable))
        else begin
            fail_count++;
            $error("pready outside an APB access phase");
        end

    // One completion cycle per transfer, right after the ack
    pready_per_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> ##(`TIMER_ACK_DELAY + 1) pready ##1 !pready)
        else begin
            fail_count++;
            $error("pready missing or held longer than one cycle after a transfer");
        end

endmodule

bind apb_bridge apb_timer_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .req     (bus.req),
    .ack     (bus.ack)
);

/* dv/apb_timer_tb.sv */
`include "apb_timer_settings.svh"

module apb_timer_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import apb_timer_pkg::*;

    localparam int ACCESS_CYCLES = `TIMER_ACK_DELAY + 1;
    localparam int CHK_NONE      = 0;
    localparam int CHK_DATA      = 1;
    localparam int CHK_SAME      = 2;
    localparam int IRQ_ANY       = -1;
    localparam int MARGIN        = 50;

    typedef struct packed {
        access_op_e                     op;
        logic [`APB_TIMER_ADDR_W-1:0]   ofs;
        logic [`APB_TIMER_DATA_W-1:0]   wdata;
        logic [`APB_TIMER_DATA_W-1:0]   exp_rdata;
        int                             chk;
        int                             irq_exp;
        int                             idle;
    } step_t;

    logic                           clk;
    logic                           rst_n;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`APB_TIMER_ADDR_W-1:0]   paddr;
    logic [`APB_TIMER_DATA_W-1:0]   pwdata;
    logic [`APB_TIMER_DATA_W-1:0]   prdata;
    logic                           pready;
    logic                           irq;

    step_t          steps[$];
    logic [31:0]    lcg_state = 32'h83d3_d228;
    logic [31:0]    prev_rdata = '0;
    int             cycle_count = 0;
    int             cycle_limit = 0;

    apb_timer u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run exceeded %0d clock cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic void add_step(input access_op_e op, input logic [11:0] ofs,
                                     input logic [31:0] wdata, input logic [31:0] exp_rdata,
                                     input int chk, input int irq_exp, input int idle);
        step_t s;
        s.op        = op;
        s.ofs       = ofs;
        s.wdata     = wdata;
        s.exp_rdata = exp_rdata;
        s.chk       = chk;
        s.irq_exp   = irq_exp;
        s.idle      = idle;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        logic [31:0] value;
        // Registers after reset
        add_step(op_read, `TIMER_CTRL_OFS, 0, 0, CHK_DATA, 0, 0);
        add_step(op_read, `TIMER_STATUS_OFS, 0, 0, CHK_DATA, 0, 0);
        add_step(op_read, `TIMER_COUNT_OFS, 0, 0, CHK_DATA, 0, 0);
        for (int i = 0; i < 16; i++) begin
            value = next_random();
            add_step(op_write, `TIMER_LOAD_OFS, value, 0, CHK_NONE, IRQ_ANY, 0);
            add_step(op_read, `TIMER_LOAD_OFS, 0, value, CHK_DATA, IRQ_ANY, i % 3);
        end
        // Unmapped offset ignores writes
        add_step(op_write, 12'h010, 32'hdead_beef, 0, CHK_NONE, IRQ_ANY, 0);
        add_step(op_read, 12'h010, 0, 0, CHK_DATA, IRQ_ANY, 0);
        // One-shot with irq enabled
        add_step(op_write, `TIMER_LOAD_OFS, 32'd5, 0, CHK_NONE, IRQ_ANY, 0);
        add_step(op_write, `TIMER_CTRL_OFS, 32'h5, 0, CHK_NONE, IRQ_ANY, 20);
        add_step(op_read, `TIMER_COUNT_OFS, 0, 0, CHK_DATA, 1, 0);
        add_step(op_read, `TIMER_CTRL_OFS, 0, 32'h4, CHK_DATA, 1, 0);
        add_step(op_read, `TIMER_STATUS_OFS, 0, 32'h1, CHK_DATA, 1, 0);
        // Write 1 to clear
        add_step(op_write, `TIMER_STATUS_OFS, 32'h1, 0, CHK_NONE, 0, 0);
        add_step(op_read, `TIMER_STATUS_OFS, 0, 0, CHK_DATA, 0, 0);
        // Periodic, irq masked
        add_step(op_write, `TIMER_LOAD_OFS, 32'd3, 0, CHK_NONE, 0, 0);
        add_step(op_write, `TIMER_CTRL_OFS, 32'h3, 0, CHK_NONE, 0, 12);
        add_step(op_read, `TIMER_STATUS_OFS, 0, 32'h1, CHK_DATA, 0, 0);
        add_step(op_read, `TIMER_CTRL_OFS, 0, 32'h3, CHK_DATA, 0, 0);
        // Stop freezes the count
        add_step(op_write, `TIMER_CTRL_OFS, 32'h0, 0, CHK_NONE, 0, 0);
        add_step(op_read, `TIMER_CTRL_OFS, 0, 0, CHK_DATA, 0, 0);
        add_step(op_read, `TIMER_COUNT_OFS, 0, 0, CHK_NONE, 0, 6);
        add_step(op_read, `TIMER_COUNT_OFS, 0, 0, CHK_SAME, 0, 0);
    endfunction

    // Starts at 1 ns after an edge, returns at the same phase
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output int cycles);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = write ? wdata : '0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles  = 1;
        while (!pready) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata,
                             output int cycles);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, wdata, unused, cycles);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata,
                            output int cycles);
        apb_transfer(1'b0, addr, '0, rdata, cycles);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_step(input step_t s, input int index);
        logic [31:0] rdata;
        int          cycles;
        rdata = '0;
        if (s.op == op_write) begin
            apb_write(s.ofs, s.wdata, cycles);
        end else begin
            apb_read(s.ofs, rdata, cycles);
        end
        check_value($sformatf("access cycles (step %0d)", index), ACCESS_CYCLES, cycles);
        if (s.chk == CHK_DATA) begin
            check_value($sformatf("prdata (step %0d)", index), s.exp_rdata, rdata);
        end else if (s.chk == CHK_SAME) begin
            check_value($sformatf("prdata (step %0d)", index), prev_rdata, rdata);
        end
        if (s.op == op_read) begin
            prev_rdata = rdata;
        end
        if (s.irq_exp != IRQ_ANY) begin
            check_value($sformatf("irq (step %0d)", index), s.irq_exp, {31'b0, irq});
        end
        wait_cycles(s.idle);
    endtask

    initial begin
        int idle_sum;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        build_table();
        idle_sum = 0;
        foreach (steps[i]) begin
            idle_sum += steps[i].idle;
        end
        cycle_limit = steps.size() * (`TIMER_ACK_DELAY + 2) + idle_sum + 4 + MARGIN;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("pready", 32'h0, {31'b0, pready});
        check_value("irq", 32'h0, {31'b0, irq});

        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i], i);
        end

        if (u_dut.u_bridge.u_chk.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Handshake assertions failed %0d times",
                     u_dut.u_bridge.u_chk.fail_count);
            $display("RESULT: FAIL");
            $fatal(1, "handshake assertions failed");
        end
    end

endmodule

/* apb_timer.f */
+incdir+source
source/apb_timer_pkg.sv
source/apb_timer_ifs.sv
source/apb_bridge.sv
source/timer_regs.sv
source/timer_core.sv
source/apb_timer.sv
dv/apb_timer_chk.sv
dv/apb_timer_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the APB timer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f apb_timer.f --top-module apb_timer_tb -o apb_timer_sim

status=0
out=$(./obj_dir/apb_timer_sim 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi

echo "simulation did not pass (exit status $status)"
exit 1
